/* Makefile */
# Verilator build and run for the AES-128 pipeline testbench

VERILATOR ?= verilator
TOP       ?= aes_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Some tests failed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/aes_cases.txt */
# AES-128 test vectors, all in hex
# key plaintext expected_ciphertext
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
00000000000000000000000000000000 96ab5c2ff612d9dfaae8c31f30c42168 ff4f8391a6a40ca5b25d23bedd44a597
10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465
caea65cdbb75e9169ecd22ebe6e54675 00000000000000000000000000000000 6e29201190152df4ee058139def610bb
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8

/* bench/aes_tb.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_tb
    import aes_pkg::*;
;

    localparam int          LAT          = `AES_LATENCY;
    localparam int          MAX_GAP      = 3;      // Idle cycles between blocks in the gap test
    localparam int          FLUSH_BURST  = 5;
    localparam int          FLUSH_WAIT   = 8;      // Well short of LAT so blocks stay in flight
    localparam int          QUIET_CYCLES = 25;
    localparam int unsigned SEED         = 32'h6eb0_4fa7;
    localparam string       CASES_FILE   = "bench/aes_cases.txt";

    typedef struct packed {
        aes_block_t key;
        aes_block_t plaintext;
        aes_block_t expected;
    } vector_t;

    // One accepted block waiting for its result
    typedef struct packed {
        aes_block_t  ciphertext;
        logic [31:0] accept;       // Cycle in which the block sits on the inputs
    } pending_t;

    logic       clk;
    logic       rst_n;
    aes_req_t   req;
    logic       in_valid;
    aes_block_t ciphertext;
    logic       out_valid;

    vector_t    cases [$];
    pending_t   exp_q [$];
    pending_t   head;
    int         cycle   = 0;
    int         errors  = 0;
    int         results = 0;
    int         budget  = 0;

    aes128_encrypt u_aes128_encrypt (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .in_valid   (in_valid),
        .ciphertext (ciphertext),
        .out_valid  (out_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    function automatic aes_block_t random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Enough cycles for every phase of the run
    function automatic int run_budget(int n);
        return 3 + n * (LAT + 4) + (n + LAT + 4) + (n * (MAX_GAP + 1) + LAT + 4)
               + (FLUSH_BURST + FLUSH_WAIT + 3 + QUIET_CYCLES + 3 + LAT + 4) + 50;
    endfunction

    task automatic load_cases();
        int         fd;
        int         rc;
        string      line;
        aes_block_t k;
        aes_block_t p;
        aes_block_t c;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
        begin
            errors++;
            $display("ERROR: cannot open the case file %s", CASES_FILE);
            return;
        end
        while (!$feof(fd))
        begin
            rc = $fgets(line, fd);
            if (rc == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;                               // Blank or comment line
            if ($sscanf(line, "%h %h %h", k, p, c) == 3)
                cases.push_back(vector_t'{key: k, plaintext: p, expected: c});
            else
            begin
                errors++;
                $display("ERROR: unreadable line in the case file: %s", line);
            end
        end
        $fclose(fd);
    endtask

    // Starts just after a falling edge and returns at the next one
    task automatic drive_block(int idx);
        req.key       = cases[idx].key;
        req.plaintext = cases[idx].plaintext;
        in_valid      = 1'b1;
        exp_q.push_back(pending_t'{ciphertext: cases[idx].expected, accept: cycle});
        @(negedge clk);
    endtask

    task automatic idle_cycles(int n);
        in_valid      = 1'b0;
        req.key       = random_block();     // Filler the DUT must ignore
        req.plaintext = random_block();
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
    endtask

    // --------------------------------------------------
    // Monitor and scoreboard
    // --------------------------------------------------
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("ERROR at %0t: out_valid high with no block in flight", $time);
            end
            else
            begin
                head = exp_q.pop_front();
                results++;
                check_value("latency", 128'(cycle - int'(head.accept)), 128'(LAT));
                check_value("ciphertext", ciphertext, head.ciphertext);
            end
        end
        else if (exp_q.size() != 0 && int'(exp_q[0].accept) + LAT <= cycle)
        begin
            errors++;
            $display("ERROR at %0t: no result for the block accepted in cycle %0d",
                     $time, exp_q[0].accept);
            void'(exp_q.pop_front());
        end
    end

    initial
    begin
        wait (budget != 0);
        repeat (budget) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, %0d results pending, %0d errors",
                 budget, exp_q.size(), errors);
        $display("Some tests failed");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        void'($urandom(SEED));
        load_cases();
        if (cases.size() == 0)
        begin
            errors++;
            $display("ERROR: no test vectors were loaded");
        end
        budget = run_budget(cases.size());
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        $display("Known answer, %0d cases one at a time", cases.size());
        foreach (cases[i])
        begin
            drive_block(i);
            idle_cycles(1);
            wait_drain();
        end

        $display("Streaming on consecutive cycles");
        foreach (cases[i])
            drive_block(i);
        wait_drain();

        $display("Random idle gaps");
        foreach (cases[i])
        begin
            drive_block(i);
            idle_cycles($urandom_range(MAX_GAP, 0));
        end
        wait_drain();

        $display("Reset with blocks in flight");
        for (int i = 0; i < FLUSH_BURST && i < cases.size(); i++)
            drive_block(i);
        idle_cycles(FLUSH_WAIT);
        rst_n = 1'b0;
        exp_q.delete();                             // These blocks never come out
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(QUIET_CYCLES);
        for (int i = 0; i < 3 && i < cases.size(); i++)
            drive_block(i);
        wait_drain();
        idle_cycles(2);

        $display("Checked %0d results with %0d errors", results, errors);
        if (errors == 0 && exp_q.size() == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/aes_pkg.sv
src/aes_sbox_word.sv
src/aes_key_stage.sv
src/aes_round_stage.sv
src/aes128_encrypt.sv
bench/aes_tb.sv

/* src/aes128_encrypt.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes128_encrypt
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  aes_req_t   req,
    input  logic       in_valid,
    output aes_block_t ciphertext,
    output logic       out_valid
);

    aes_round_t                  whiten_q;                // Stage 0 state and key
    aes_round_t                  link [0:`AES_ROUNDS];    // Output of each stage
    logic [`AES_LATENCY-1:0]     valid_q;

    // --------------------------------------------------
    // Input whitening, one cycle
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        whiten_q.state <= req.plaintext ^ req.key;    // Round 0 AddRoundKey
        whiten_q.key   <= req.key;
    end

    assign link[0] = whiten_q;

    // --------------------------------------------------
    // Ten rounds, key and state in lock-step
    // --------------------------------------------------
    for (genvar k = 1; k <= `AES_ROUNDS; k++)
    begin : g_round
        aes_block_t key_next;
        aes_block_t key_early;      // Round key k, one cycle ahead of key_next
        aes_block_t state_next;

        aes_key_stage #(
            .round_index (k)
        ) u_key_stage (
            .clk       (clk),
            .key_in    (link[k-1].key),
            .key_out   (key_next),
            .key_early (key_early)
        );

        aes_round_stage #(
            .final_round (k == `AES_ROUNDS)
        ) u_round_stage (
            .clk       (clk),
            .state_in  (link[k-1].state),
            .round_key (key_early),
            .state_out (state_next)
        );

        assign link[k] = '{state: state_next, key: key_next};
    end

    assign ciphertext = link[`AES_ROUNDS].state;

    // --------------------------------------------------
    // Valid tag, travels with the data
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= '0;                                      // Flush in-flight tags
        else
            valid_q <= {valid_q[`AES_LATENCY-2:0], in_valid};
    end

    assign out_valid = valid_q[`AES_LATENCY-1];

endmodule

/* src/aes_defines.svh */
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// Cipher rounds for a 128-bit key
`define AES_ROUNDS       10
`define AES_BLOCK_W      128
`define AES_WORD_W       32
`define AES_BYTE_W       8

// Register stages per round, substitution then mix-and-add
`define AES_ROUND_CYCLES 2
`define AES_LATENCY      (1 + `AES_ROUNDS * `AES_ROUND_CYCLES)

`endif

/* src/aes_key_stage.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_key_stage
    import aes_pkg::*;
#(
    parameter int round_index = 1
)(
    input  logic       clk,
    input  aes_block_t key_in,
    output aes_block_t key_out,
    output aes_block_t key_early
);

    // Round constant is x^(round_index-1) in GF(2^8)
    function automatic aes_byte_t rcon_of(int idx);
        aes_byte_t r;
        r = 8'h01;
        for (int i = 1; i < idx; i++)
            r = xtime(r);
        return r;
    endfunction

    localparam aes_byte_t rcon = rcon_of(round_index);

    aes_word_t  k0, k1, k2, k3;
    aes_word_t  v0, v1, v2, v3;
    aes_word_t  sub_w;          // SubWord(RotWord(w3)), valid in second cycle
    aes_block_t prefix_q;

    assign {k0, k1, k2, k3} = key_in;

    // --------------------------------------------------
    // First cycle, prefix XOR chain
    // --------------------------------------------------
    assign v0 = k0 ^ {rcon, {(`AES_WORD_W - `AES_BYTE_W){1'b0}}};  // Rcon on top byte
    assign v1 = v0 ^ k1;
    assign v2 = v1 ^ k2;
    assign v3 = v2 ^ k3;

    always_ff @(posedge clk)
        prefix_q <= {v0, v1, v2, v3};

    aes_sbox_word u_sbox_word (
        .clk      (clk),
        .word_in  ({k3[`AES_WORD_W-`AES_BYTE_W-1:0], k3[`AES_WORD_W-1 -: `AES_BYTE_W]}),
        .word_out (sub_w)
    );

    // --------------------------------------------------
    // Second cycle, fold substituted word into all four
    // --------------------------------------------------
    assign key_early = prefix_q ^ {4{sub_w}};   // Feeds the matching round stage

    always_ff @(posedge clk)
        key_out <= key_early;

endmodule

/* src/aes_pkg.sv */
`include "aes_defines.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;  // State or key
    typedef logic [`AES_WORD_W-1:0]  aes_word_t;   // One column
    typedef logic [`AES_BYTE_W-1:0]  aes_byte_t;

    // Input bundle sampled on every cycle
    typedef struct packed {
        aes_block_t key;
        aes_block_t plaintext;
    } aes_req_t;

    // Carried from one pipeline stage to the next
    typedef struct packed {
        aes_block_t state;
        aes_block_t key;
    } aes_round_t;

    // --------------------------------------------------
    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    // --------------------------------------------------
    function automatic aes_byte_t xtime(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

/* src/aes_round_stage.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_round_stage
    import aes_pkg::*;
#(
    parameter bit final_round = 1'b0
)(
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,   // Aligned with the second cycle
    output aes_block_t state_out
);

    localparam int ncols = `AES_BLOCK_W / `AES_WORD_W;
    localparam int nrows = `AES_WORD_W / `AES_BYTE_W;

    aes_block_t sub_q;              // SubBytes result, first register
    aes_block_t shifted;
    aes_block_t mixed;

    // --------------------------------------------------
    // Cycle 1, SubBytes on every column
    // --------------------------------------------------
    for (genvar c = 0; c < ncols; c++)
    begin : g_col
        aes_sbox_word u_sbox_word (
            .clk      (clk),
            .word_in  (state_in[`AES_BLOCK_W-1 - c*`AES_WORD_W -: `AES_WORD_W]),
            .word_out (sub_q[`AES_BLOCK_W-1 - c*`AES_WORD_W -: `AES_WORD_W])
        );
    end

    // Row r of column c moves from column (c + r) mod 4
    function automatic aes_block_t shift_rows(aes_block_t s);
        aes_block_t r;
        int         src;
        int         dst;
        r = '0;
        for (int c = 0; c < ncols; c++)
        begin
            for (int row = 0; row < nrows; row++)
            begin
                dst = `AES_BLOCK_W-1 - (c*nrows + row)*`AES_BYTE_W;
                src = `AES_BLOCK_W-1 - (((c + row) % ncols)*nrows + row)*`AES_BYTE_W;
                r[dst -: `AES_BYTE_W] = s[src -: `AES_BYTE_W];
            end
        end
        return r;
    endfunction

    // Column times the fixed matrix {02 03 01 01}
    function automatic aes_word_t mix_column(aes_word_t w);
        aes_byte_t a0, a1, a2, a3;
        aes_byte_t m0, m1, m2, m3;
        {a0, a1, a2, a3} = w;
        m0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        m1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        m2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        m3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        return {m0, m1, m2, m3};
    endfunction

    function automatic aes_block_t mix_columns(aes_block_t s);
        aes_block_t r;
        for (int c = 0; c < ncols; c++)
        begin
            r[`AES_BLOCK_W-1 - c*`AES_WORD_W -: `AES_WORD_W] =
                mix_column(s[`AES_BLOCK_W-1 - c*`AES_WORD_W -: `AES_WORD_W]);
        end
        return r;
    endfunction

    // --------------------------------------------------
    // Cycle 2, ShiftRows, MixColumns and AddRoundKey
    // --------------------------------------------------
    always_comb
    begin
        shifted = shift_rows(sub_q);
        mixed   = final_round ? shifted : mix_columns(shifted);  // Last round skips mixing
    end

    always_ff @(posedge clk)
        state_out <= mixed ^ round_key;

endmodule

/* src/aes_sbox_word.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_sbox_word
    import aes_pkg::*;
(
    input  logic      clk,
    input  aes_word_t word_in,
    output aes_word_t word_out
);

    // --------------------------------------------------
    // GF(2^8) arithmetic
    // --------------------------------------------------
    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < `AES_BYTE_W; i++)
        begin
            if (b[i])
                acc = acc ^ sh;     // Add shifted partial product
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic aes_byte_t gf_inv(aes_byte_t a);
        aes_byte_t x2;
        aes_byte_t x3;
        aes_byte_t x12;
        aes_byte_t x15;
        aes_byte_t x240;
        x2  = gf_mul(a, a);
        x3  = gf_mul(x2, a);
        x12 = gf_mul(x3, x3);       // a^6
        x12 = gf_mul(x12, x12);     // a^12
        x15 = gf_mul(x12, x3);
        x240 = x15;
        for (int i = 0; i < 4; i++)
            x240 = gf_mul(x240, x240);  // a^30 .. a^240
        return gf_mul(gf_mul(x240, x12), x2);  // a^252 * a^2
    endfunction

    // Affine transform of the S-box
    function automatic aes_byte_t affine(aes_byte_t b);
        aes_byte_t r1;
        aes_byte_t r2;
        aes_byte_t r3;
        aes_byte_t r4;
        r1 = {b[6:0], b[7]};
        r2 = {b[5:0], b[7:6]};
        r3 = {b[4:0], b[7:5]};
        r4 = {b[3:0], b[7:4]};
        return b ^ r1 ^ r2 ^ r3 ^ r4 ^ 8'h63;
    endfunction

    // --------------------------------------------------
    // Registered substitution of all four bytes
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `AES_WORD_W / `AES_BYTE_W; i++)
        begin
            word_out[i*`AES_BYTE_W +: `AES_BYTE_W] <=
                affine(gf_inv(word_in[i*`AES_BYTE_W +: `AES_BYTE_W]));
        end
    end

endmodule
